// File: common/apb1_macros.svh
// APB1 bridge build constants
// Slave count, bus widths and the address window of each leaf slave

`ifndef APB1_MACROS_SVH
`define APB1_MACROS_SVH

// Leaf slave count
`define APB1_SLV_NUM    4

// Bus widths
`define APB1_ADDR_W     32
`define APB1_DATA_W     32

// ********************************************************************
// Leaf windows, 4 KB each, bounds inclusive
// ********************************************************************
`define APB1_SLV0_BASE  32'h4000_0000
`define APB1_SLV0_END   32'h4000_0FFF

`define APB1_SLV1_BASE  32'h4000_1000
`define APB1_SLV1_END   32'h4000_1FFF

`define APB1_SLV2_BASE  32'h4000_2000
`define APB1_SLV2_END   32'h4000_2FFF

`define APB1_SLV3_BASE  32'h4000_3000
`define APB1_SLV3_END   32'h4000_3FFF

`endif

// File: common/apb1_pkg.sv
// APB1 bridge types
// Bus field widths, per-slave vectors and the bridge state encoding

`include "apb1_macros.svh"

package apb1_pkg;

    // AHB and APB bus fields
    typedef logic [`APB1_ADDR_W-1:0]      addr_t;
    typedef logic [`APB1_DATA_W-1:0]      data_t;
    typedef logic [`APB1_DATA_W/8-1:0]    strb_t;
    typedef logic [2:0]                   pprot_t;
    typedef logic [1:0]                   htrans_t;
    typedef logic [2:0]                   hsize_t;
    typedef logic [3:0]                   hprot_t;
    typedef logic [1:0]                   hresp_t;

    // One bit per leaf slave
    typedef logic [`APB1_SLV_NUM-1:0]     slv_vec_t;

    // Read data of all leaf slaves, slave 0 in the low word
    typedef logic [`APB1_SLV_NUM-1:0][`APB1_DATA_W-1:0] slv_rdata_t;

    // Transfer sequencing, one-hot
    typedef enum logic [6:0]
    {
        IDLE      = 7'b000_0001,
        WAIT_WR   = 7'b000_0010,  // Slot for the AHB data phase
        SETUP_WR  = 7'b000_0100,
        ACCESS_WR = 7'b000_1000,
        WAIT_RD   = 7'b001_0000,  // Waiting for the first enable
        SETUP_RD  = 7'b010_0000,
        ACCESS_RD = 7'b100_0000
    } bridge_state_e;

endpackage

// File: common/apb1_root_if.sv
// APB bus between the bridge and the leaf decoder
// Control from the FSM, payload from the request capture,
// response from the decoder

`timescale 1ns/1ns

interface apb1_root_if;
    import apb1_pkg::*;

    logic     psel;
    logic     penable;
    addr_t    paddr;
    data_t    pwdata;
    strb_t    pstrb;
    logic     pwrite;
    pprot_t   pprot;
    logic     pready;
    logic     pslverr;
    data_t    prdata;

    // Phase control and response sampling
    modport fsm_mp
    (
        output psel,
        output penable,
        input  pready,
        input  pslverr,
        input  prdata
    );

    // Registered address phase and write data
    modport capture_mp
    (
        output paddr,
        output pwdata,
        output pstrb,
        output pwrite,
        output pprot
    );

    modport decoder_mp
    (
        input  psel,
        input  paddr,
        output pready,
        output pslverr,
        output prdata
    );

endinterface

// File: hw/bridge/apb1_phase_fsm.sv
// APB1 transfer sequencer
// Walks AHB requests through the APB setup and access phases on the
// APB clock enable, drives AHB ready-out, the error response and read data

`timescale 1ns/1ns

module apb1_phase_fsm
(
    input  logic                i_hclk,
    input  logic                i_hrst_n,
    input  logic                i_pclk_en,
    input  logic                i_hsel,
    input  logic                i_hreadyin,
    input  logic                i_hwrite,
    input  apb1_pkg::htrans_t   i_htrans,
    output logic                o_hreadyout,
    output apb1_pkg::hresp_t    o_hresp,
    output apb1_pkg::data_t     o_hrdata,
    output logic                o_addr_load,
    output logic                o_wdata_load,
    apb1_root_if.fsm_mp         bus
);
    import apb1_pkg::*;

    bridge_state_e  state;
    bridge_state_e  state_nxt;
    logic           ahb_req;
    logic           accept;
    logic           setup_nxt;
    logic           access_nxt;
    logic           xfer_done;
    logic           xfer_err;
    logic           err_hold;

    assign ahb_req   = i_hsel & i_htrans[1] & i_hreadyin;  // NONSEQ or SEQ
    assign accept    = ahb_req & o_hreadyout;
    assign xfer_done = bus.penable & bus.pready & i_pclk_en;
    assign xfer_err  = bus.psel & bus.penable & bus.pready & bus.pslverr;

    // ********************************************************************
    // State machine
    // ********************************************************************
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:
            begin
                if (accept && i_hwrite)
                    state_nxt = WAIT_WR;
                else if (accept)
                    state_nxt = i_pclk_en ? SETUP_RD : WAIT_RD;
            end
            WAIT_WR:
            begin
                if (i_pclk_en)
                    state_nxt = SETUP_WR;
            end
            SETUP_WR:
            begin
                if (i_pclk_en)
                    state_nxt = ACCESS_WR;
            end
            WAIT_RD:
            begin
                if (i_pclk_en)
                    state_nxt = SETUP_RD;
            end
            SETUP_RD:
            begin
                if (i_pclk_en)
                    state_nxt = ACCESS_RD;
            end
            ACCESS_WR, ACCESS_RD:
            begin
                if (i_pclk_en && bus.pready)
                    state_nxt = IDLE;
            end
            default:
                state_nxt = IDLE;
        endcase
    end

    assign setup_nxt  = (state_nxt == SETUP_WR) || (state_nxt == SETUP_RD);
    assign access_nxt = (state_nxt == ACCESS_WR) || (state_nxt == ACCESS_RD);

    // APB control
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
        begin
            bus.psel    <= 1'b0;
            bus.penable <= 1'b0;
        end
        else
        begin
            bus.psel    <= setup_nxt | access_nxt;
            bus.penable <= access_nxt;
        end
    end

    // ********************************************************************
    // AHB side
    // ********************************************************************
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            o_hreadyout <= 1'b1;
        else if (o_hreadyout)
            o_hreadyout <= ~accept;
        else if (xfer_done)
            o_hreadyout <= 1'b1;
    end

    assign o_addr_load = o_hreadyout;

    // Write data arrives one cycle after its address
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            o_wdata_load <= 1'b0;
        else
            o_wdata_load <= accept & i_hwrite;
    end

    // Error stays up for the first ready cycle
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            err_hold <= 1'b0;
        else if (i_pclk_en)
            err_hold <= xfer_err;
        else if (o_hreadyout)
            err_hold <= 1'b0;
    end

    assign o_hresp = {1'b0, (xfer_err & i_pclk_en) | err_hold};  // OKAY or ERROR

    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            o_hrdata <= '0;
        else if (state == ACCESS_RD && bus.pready && i_pclk_en)
            o_hrdata <= bus.prdata;
    end

    // Access phase is always preceded by its setup cycle
    a_penable_after_setup: assert property (@(posedge i_hclk) disable iff (!i_hrst_n)
        bus.penable |-> bus.psel && $past(bus.psel));

    a_wait_not_idle: assert property (@(posedge i_hclk) disable iff (!i_hrst_n)
        !o_hreadyout && !$past(accept) |-> state != IDLE);

endmodule

// File: hw/bridge/ahb_req_capture.sv
// AHB address phase capture
// Holds address, direction, byte strobes and protection for the APB
// transfer, and latches write data from the AHB data phase

`timescale 1ns/1ns

module ahb_req_capture
(
    input  logic                i_hclk,
    input  logic                i_hrst_n,
    input  logic                i_addr_load,
    input  logic                i_wdata_load,
    input  apb1_pkg::addr_t     i_haddr,
    input  logic                i_hwrite,
    input  logic                i_hsec,
    input  apb1_pkg::hsize_t    i_hsize,
    input  apb1_pkg::hprot_t    i_hprot,
    input  apb1_pkg::data_t     i_hwdata,
    apb1_root_if.capture_mp     bus
);
    import apb1_pkg::*;

    strb_t   byte_strb;
    pprot_t  prot_map;

    // Byte lanes from size and low address bits, misaligned gives none
    always_comb
    begin
        byte_strb = '0;
        case (i_hsize)
            3'b000:
                byte_strb = strb_t'(4'b0001 << i_haddr[1:0]);
            3'b001:
            begin
                if (i_haddr[1:0] == 2'b00)
                    byte_strb = 4'b0011;
                else if (i_haddr[1:0] == 2'b10)
                    byte_strb = 4'b1100;
            end
            3'b010:
            begin
                if (i_haddr[1:0] == 2'b00)
                    byte_strb = 4'b1111;
            end
            default:
                byte_strb = '0;
        endcase
    end

    // Instruction / non-secure / privileged
    assign prot_map = {~i_hprot[0], ~i_hsec, i_hprot[1]};

    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
        begin
            bus.paddr  <= '0;
            bus.pwrite <= 1'b0;
            bus.pstrb  <= '0;
            bus.pprot  <= '0;
        end
        else if (i_addr_load)
        begin
            bus.paddr  <= i_haddr;
            bus.pwrite <= i_hwrite;
            bus.pstrb  <= byte_strb;
            bus.pprot  <= prot_map;
        end
    end

    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
            bus.pwdata <= '0;
        else if (i_wdata_load)
            bus.pwdata <= i_hwdata;  // AHB data phase
    end

endmodule

// File: hw/apb1_leaf_decoder.sv
// APB1 leaf decoder
// Maps the root address onto the leaf windows, routes the response of
// the selected slave back, answers unmapped addresses with an error

`timescale 1ns/1ns

`include "apb1_macros.svh"

module apb1_leaf_decoder
(
    apb1_root_if.decoder_mp         bus,
    output apb1_pkg::slv_vec_t      o_psel,
    input  apb1_pkg::slv_vec_t      i_pready,
    input  apb1_pkg::slv_vec_t      i_pslverr,
    input  apb1_pkg::slv_rdata_t    i_prdata
);
    import apb1_pkg::*;

    slv_vec_t  win_hit;
    logic      no_hit;

    // Window match
    assign win_hit[0] = (bus.paddr >= `APB1_SLV0_BASE) && (bus.paddr <= `APB1_SLV0_END);
    assign win_hit[1] = (bus.paddr >= `APB1_SLV1_BASE) && (bus.paddr <= `APB1_SLV1_END);
    assign win_hit[2] = (bus.paddr >= `APB1_SLV2_BASE) && (bus.paddr <= `APB1_SLV2_END);
    assign win_hit[3] = (bus.paddr >= `APB1_SLV3_BASE) && (bus.paddr <= `APB1_SLV3_END);

    assign o_psel = bus.psel ? win_hit : '0;
    assign no_hit = bus.psel & ~(|win_hit);

    // Unmapped access completes at once with an error
    assign bus.pready  = (|(o_psel & i_pready)) | no_hit;
    assign bus.pslverr = (|(o_psel & i_pslverr)) | no_hit;

    always_comb
    begin
        bus.prdata = '0;
        for (int i = 0; i < `APB1_SLV_NUM; i++)
        begin
            if (win_hit[i])
                bus.prdata = i_prdata[i];
        end
    end

    // Windows must not overlap
    always_comb
    begin
        a_psel_onehot: assert final ($onehot0(o_psel))
            else $error("leaf selects not one-hot: %b", o_psel);
    end

endmodule

// File: hw/apb1_bridge_top.sv
// AHB to APB1 bridge with leaf decode
// AHB slave in, four APB leaf slaves out on shared payload lines

`timescale 1ns/1ns

module apb1_bridge_top
(
    input  logic                    i_hclk,
    input  logic                    i_hrst_n,
    input  logic                    i_pclk_en,
    input  logic                    i_hsel,
    input  logic                    i_hreadyin,
    input  apb1_pkg::addr_t         i_haddr,
    input  logic                    i_hwrite,
    input  apb1_pkg::htrans_t       i_htrans,
    input  apb1_pkg::hsize_t        i_hsize,
    input  apb1_pkg::hprot_t        i_hprot,
    input  logic                    i_hsec,
    input  apb1_pkg::data_t         i_hwdata,
    output logic                    o_hreadyout,
    output apb1_pkg::hresp_t        o_hresp,
    output apb1_pkg::data_t         o_hrdata,
    output apb1_pkg::slv_vec_t      o_psel,
    output apb1_pkg::addr_t         o_paddr,
    output logic                    o_penable,
    output apb1_pkg::data_t         o_pwdata,
    output apb1_pkg::strb_t         o_pstrb,
    output logic                    o_pwrite,
    output apb1_pkg::pprot_t        o_pprot,
    input  apb1_pkg::slv_vec_t      i_pready,
    input  apb1_pkg::slv_vec_t      i_pslverr,
    input  apb1_pkg::slv_rdata_t    i_prdata
);

    logic  addr_load;
    logic  wdata_load;

    apb1_root_if root_bus ();

    apb1_phase_fsm u_phase_fsm
    (
        .i_hclk        (i_hclk),
        .i_hrst_n      (i_hrst_n),
        .i_pclk_en     (i_pclk_en),
        .i_hsel        (i_hsel),
        .i_hreadyin    (i_hreadyin),
        .i_hwrite      (i_hwrite),
        .i_htrans      (i_htrans),
        .o_hreadyout   (o_hreadyout),
        .o_hresp       (o_hresp),
        .o_hrdata      (o_hrdata),
        .o_addr_load   (addr_load),
        .o_wdata_load  (wdata_load),
        .bus           (root_bus)
    );

    ahb_req_capture u_req_capture
    (
        .i_hclk        (i_hclk),
        .i_hrst_n      (i_hrst_n),
        .i_addr_load   (addr_load),
        .i_wdata_load  (wdata_load),
        .i_haddr       (i_haddr),
        .i_hwrite      (i_hwrite),
        .i_hsec        (i_hsec),
        .i_hsize       (i_hsize),
        .i_hprot       (i_hprot),
        .i_hwdata      (i_hwdata),
        .bus           (root_bus)
    );

    apb1_leaf_decoder u_leaf_decoder
    (
        .bus           (root_bus),
        .o_psel        (o_psel),
        .i_pready      (i_pready),
        .i_pslverr     (i_pslverr),
        .i_prdata      (i_prdata)
    );

    // Shared leaf payload
    assign o_paddr   = root_bus.paddr;
    assign o_penable = root_bus.penable;
    assign o_pwdata  = root_bus.pwdata;
    assign o_pstrb   = root_bus.pstrb;
    assign o_pwrite  = root_bus.pwrite;
    assign o_pprot   = root_bus.pprot;

endmodule

// File: tests/tb_apb1_bridge.sv
// AHB to APB1 bridge testbench
// Random AHB transfers into four behavioral APB slaves with wait states,
// checked against a memory model and the APB phase rules

`timescale 1ns/1ns

`include "apb1_macros.svh"

module tb_apb1_bridge;
    import apb1_pkg::*;

    localparam int N_XFER  = 400;
    localparam int TIMEOUT = N_XFER * 40;

    logic         clk;
    logic         rst_n;
    logic         pclk_en;
    logic         hsel;
    logic         hreadyin;
    addr_t        haddr;
    logic         hwrite;
    htrans_t      htrans;
    hsize_t       hsize;
    hprot_t       hprot;
    logic         hsec;
    data_t        hwdata;
    logic         hreadyout;
    hresp_t       hresp;
    data_t        hrdata;
    slv_vec_t     psel;
    addr_t        paddr;
    logic         penable;
    data_t        pwdata;
    strb_t        pstrb;
    logic         pwrite;
    pprot_t       pprot;
    slv_vec_t     slv_ready;
    slv_vec_t     slv_err;
    slv_rdata_t   slv_rdata;

    logic [31:0]  drv_seed = 32'h7f51;
    logic [31:0]  en_seed  = 32'h7f51 ^ 32'h0000_1111;
    logic [31:0]  slv_seed = 32'h7f51 ^ 32'h0000_2222;
    int           cycles   = 0;

    // Expected transfer, set by the driver
    slv_vec_t     exp_sel;
    addr_t        exp_addr;
    logic         exp_write;
    data_t        exp_wdata;
    strb_t        exp_strb;
    pprot_t       exp_prot;
    logic         exp_err;

    logic [31:0]  slv_mem [4][1024];
    logic [31:0]  ref_mem [4][1024];
    logic [1:0]   wait_left [4];

    logic         prev_pen  = 1'b0;
    logic         prev_done = 1'b0;
    slv_vec_t     prev_sel;
    addr_t        prev_addr;
    data_t        prev_wdata;
    strb_t        prev_strb;

    apb1_bridge_top DUT
    (
        .i_hclk      (clk),
        .i_hrst_n    (rst_n),
        .i_pclk_en   (pclk_en),
        .i_hsel      (hsel),
        .i_hreadyin  (hreadyin),
        .i_haddr     (haddr),
        .i_hwrite    (hwrite),
        .i_htrans    (htrans),
        .i_hsize     (hsize),
        .i_hprot     (hprot),
        .i_hsec      (hsec),
        .i_hwdata    (hwdata),
        .o_hreadyout (hreadyout),
        .o_hresp     (hresp),
        .o_hrdata    (hrdata),
        .o_psel      (psel),
        .o_paddr     (paddr),
        .o_penable   (penable),
        .o_pwdata    (pwdata),
        .o_pstrb     (pstrb),
        .o_pwrite    (pwrite),
        .o_pprot     (pprot),
        .i_pready    (slv_ready),
        .i_pslverr   (slv_err),
        .i_prdata    (slv_rdata)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_rand(output logic [31:0] r);
        drv_seed = lcg_step(drv_seed);
        r = drv_seed ^ {drv_seed[15:0], drv_seed[31:16]};  // Fold high bits down
    endtask

    // Lane rule from size and low address bits
    function automatic strb_t strb_rule(input hsize_t size, input logic [1:0] off);
        case ({size, off})
            5'b000_00: return 4'b0001;
            5'b000_01: return 4'b0010;
            5'b000_10: return 4'b0100;
            5'b000_11: return 4'b1000;
            5'b001_00: return 4'b0011;
            5'b001_10: return 4'b1100;
            5'b010_00: return 4'b1111;
            default:   return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'hA5C3_0F96;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic check_idle_bus();
        check_val("o_hreadyout", hreadyout, 1);
        check_val("o_hresp", hresp, 0);
        check_val("o_psel", psel, 0);
        check_val("o_penable", penable, 0);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("Timeout: %0d transfers did not finish in %0d cycles", N_XFER, TIMEOUT);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk)
    begin
        en_seed = lcg_step(en_seed);
        pclk_en <= (en_seed[31:30] != 2'b00);  // Enabled about 3 edges in 4
    end

    // ********************************************************************
    // APB slave models
    // ********************************************************************
    assign slv_err = {4{paddr[11]}};

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            slv_rdata[i] = slv_mem[i][paddr[11:2]];
    end

    always @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (psel[i] && !penable)
            begin
                slv_seed = lcg_step(slv_seed);
                wait_left[i] <= slv_seed[31:30];
                slv_ready[i] <= (slv_seed[31:30] == 2'd0);
            end
            else if (psel[i] && pclk_en && slv_ready[i])
            begin
                // Completing edge
                for (int b = 0; b < 4; b++)
                begin
                    if (pwrite && !paddr[11] && pstrb[b])
                        slv_mem[i][paddr[11:2]][8*b +: 8] <= pwdata[8*b +: 8];
                end
                slv_ready[i] <= 1'b0;
            end
            else if (psel[i] && pclk_en)
            begin
                if (wait_left[i] == 2'd1)
                    slv_ready[i] <= 1'b1;
                wait_left[i] <= wait_left[i] - 2'd1;
            end
        end
    end

    // ********************************************************************
    // APB monitor
    // ********************************************************************
    always @(negedge clk)
    begin
        logic done_now;
        if (rst_n)
        begin
            if (psel != 0 || penable)
                check_val("o_psel", psel, exp_sel);
            if (penable)
            begin
                check_val("o_paddr", paddr, exp_addr);
                check_val("o_pwrite", pwrite, exp_write);
                check_val("o_pstrb", pstrb, exp_strb);
                check_val("o_pprot", pprot, exp_prot);
                if (exp_write)
                    check_val("o_pwdata", pwdata, exp_wdata);
            end
            if (prev_pen && !prev_done)
            begin
                check_val("o_penable", penable, 1);  // Held access phase
                check_val("o_psel", psel, prev_sel);
                check_val("o_paddr", paddr, prev_addr);
                check_val("o_pwdata", pwdata, prev_wdata);
                check_val("o_pstrb", pstrb, prev_strb);
            end
            else if (prev_pen)
                check_val("o_penable", penable, 0);
            done_now   = (exp_sel == 0) || (|(psel & slv_ready));
            prev_done  = penable && pclk_en && done_now;
            prev_pen   = penable;
            prev_sel   = psel;
            prev_addr  = paddr;
            prev_wdata = pwdata;
            prev_strb  = pstrb;
        end
    end

    // ********************************************************************
    // AHB driver and reference model
    // ********************************************************************
    initial
    begin
        logic [31:0]  r;
        int           slot;
        int           idx;
        int           gap;
        hsize_t       size;
        logic [1:0]   off;
        hprot_t       prot_in;
        logic         sec_in;

        rst_n     = 1'b0;
        pclk_en   = 1'b0;
        hsel      = 1'b0;
        hreadyin  = 1'b1;
        haddr     = '0;
        hwrite    = 1'b0;
        htrans    = 2'b00;
        hsize     = 3'b000;
        hprot     = 4'b0000;
        hsec      = 1'b0;
        hwdata    = '0;
        slv_ready = '0;
        exp_sel   = '0;
        for (int i = 0; i < 4; i++)
        begin
            wait_left[i] = 2'd0;
            for (int w = 0; w < 1024; w++)
            begin
                slv_mem[i][w] = fill_word(`APB1_SLV0_BASE + 32'(i) * 32'h1000 + 32'(w) * 4);
                ref_mem[i][w] = slv_mem[i][w];
            end
        end

        repeat (4)
        begin
            @(negedge clk);
            check_idle_bus();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_bus();

        for (int n = 0; n < N_XFER; n++)
        begin
            draw_rand(r);
            slot = r % 5;  // 4 is unmapped
            draw_rand(r);
            size = r % 3;
            off  = (size == 0) ? r[4:3] : (size == 1) ? {r[3], 1'b0} : 2'b00;
            if (slot < 4)
                exp_addr = `APB1_SLV0_BASE + 32'(slot) * 32'h1000
                           + {20'd0, (r[20:19] == 2'b00), r[18:10], off};
            else
                exp_addr = 32'h4000_4000 + {16'd0, r[25:12], off};
            exp_sel  = (slot < 4) ? slv_vec_t'(4'b0001 << slot) : '0;
            exp_err  = (slot == 4) || exp_addr[11];
            exp_strb = strb_rule(size, off);
            draw_rand(r);
            exp_write   = r[7];
            prot_in     = r[3:0];
            sec_in      = r[4];
            exp_prot[2] = ~prot_in[0];  // Instruction when not data
            exp_prot[1] = ~sec_in;
            exp_prot[0] = prot_in[1];
            gap         = r[9:8] % 3;
            draw_rand(r);
            exp_wdata = r;

            repeat (gap) @(posedge clk);
            @(posedge clk);
            hsel   <= 1'b1;
            htrans <= 2'b10;  // NONSEQ
            haddr  <= exp_addr;
            hwrite <= exp_write;
            hsize  <= size;
            hprot  <= prot_in;
            hsec   <= sec_in;
            @(posedge clk);  // Accept edge
            hsel   <= 1'b0;
            htrans <= 2'b00;
            hwdata <= exp_wdata;
            @(negedge clk);
            check_val("o_hreadyout", hreadyout, 0);
            while (!hreadyout)
                @(negedge clk);

            // First cycle with ready-out back high
            check_val("o_hresp", hresp, {1'b0, exp_err});
            if (slot < 4 && !exp_err)
            begin
                idx = exp_addr[11:2];
                if (exp_write)
                begin
                    for (int b = 0; b < 4; b++)
                    begin
                        if (exp_strb[b])
                            ref_mem[slot][idx][8*b +: 8] = exp_wdata[8*b +: 8];
                    end
                    check_val("slv_mem", slv_mem[slot][idx], ref_mem[slot][idx]);
                end
                else
                    check_val("o_hrdata", hrdata, ref_mem[slot][idx]);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+common
common/apb1_pkg.sv
common/apb1_root_if.sv
hw/bridge/apb1_phase_fsm.sv
hw/bridge/ahb_req_capture.sv
hw/apb1_leaf_decoder.sv
hw/apb1_bridge_top.sv
tests/tb_apb1_bridge.sv

// File: Bender.yml
package:
  name: apb1_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/apb1_pkg.sv
      - common/apb1_root_if.sv
      - hw/bridge/apb1_phase_fsm.sv
      - hw/bridge/ahb_req_capture.sv
      - hw/apb1_leaf_decoder.sv
      - hw/apb1_bridge_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_apb1_bridge.sv
